//--- mapper_params.svh
`ifndef MAPPER_PARAMS_SVH
`define MAPPER_PARAMS_SVH

// Bus widths
`define CPU_ADDR_W 15 // CPU A14-A0, A15 comes in as romsel
`define CPU_DATA_W 8
`define PPU_ADDR_W 14 // PPU A13-A0

// Mapped field widths
`define FLASH_BASE_W 13 // Flash base A26-A14
`define BANK_MASK_W 5 // Mask over bank A18-A14 or A17-A13
`define PRG_BANK_W 6 // Mapped CPU A18-A13
`define CHR_BANK_W 8 // Mapped PPU A17-A10
`define MAPPER_W 5 // Mapper code in setup reg 6

// Mapper codes, original numbering
`define MAP_NROM 0
`define MAP_UXROM 1
`define MAP_CNROM 2
`define MAP_AXROM 8
`define MAP_MMC3 20

// Setup registers live at $5xx0-$5xx7
`define SETUP_PAGE 3'b101 // CPU A14-A12

// MMC3 A12 filter
`define A12_LOW_CYCLES 3 // m2 edges A12 must stay low

// Fixed last 16 KiB bank, A18-A14
`define LAST_PRG_BANK 5'b11111

`endif

//--- mapper_pkg.sv
`include "mapper_params.svh"

package mapper_pkg;

	// Plain vectors with a meaning
	typedef logic [`CPU_ADDR_W-1:0] cpu_addr_t; // CPU A14-A0
	typedef logic [`CPU_DATA_W-1:0] cpu_data_t;
	typedef logic [`PPU_ADDR_W-1:0] ppu_addr_t; // PPU A13-A0
	typedef logic [`FLASH_BASE_W-1:0] flash_base_t; // A26-A14
	typedef logic [`BANK_MASK_W-1:0] bank_mask_t; // Set bits cleared from bank
	typedef logic [`PRG_BANK_W-1:0] prg_bank_t; // A18-A13
	typedef logic [`CHR_BANK_W-1:0] chr_bank_t; // A17-A10
	typedef logic [7:0] bank_reg_t;
	typedef logic [1:0] sram_page_t;

	typedef enum logic [`MAPPER_W-1:0] {
		MAPPER_NROM = `MAP_NROM,
		MAPPER_UXROM = `MAP_UXROM,
		MAPPER_CNROM = `MAP_CNROM,
		MAPPER_AXROM = `MAP_AXROM,
		MAPPER_MMC3 = `MAP_MMC3
	} mapper_e;

	typedef enum logic [1:0] {
		MIRR_VERTICAL = 2'b00, // CIRAM A10 from PPU A10
		MIRR_HORIZONTAL = 2'b01, // CIRAM A10 from PPU A11
		MIRR_ONE_A = 2'b10, // Single screen, lower page
		MIRR_ONE_B = 2'b11 // Single screen, upper page
	} mirroring_e;

	// CPU bus as seen at the m2 edge
	typedef struct packed {
		logic romsel;
		logic rw;
		cpu_addr_t addr;
		cpu_data_t data;
	} cpu_bus_t;

	typedef struct packed {
		flash_base_t flash_base;
		bank_mask_t prg_mask;
		bank_mask_t chr_mask;
		sram_page_t sram_page;
		mapper_e mapper;
		mirroring_e mirroring;
		logic sram_en;
		logic prg_wr_en;
		logic chr_wr_en;
	} mapper_cfg_t;

	// MMC3 r0-r7 plus mode bits, simple mappers use bank[0] CHR, bank[1] PRG
	typedef struct packed {
		bank_reg_t [7:0] bank;
		logic prg_mode;
		logic chr_mode;
	} bank_regs_t;

	typedef struct packed {
		cpu_data_t latch; // Counter reload value
		logic reload; // One cycle pulse on $C001
		logic enable;
	} irq_ctrl_t;

endpackage

//--- mapper_regs.sv
`include "mapper_params.svh"

module mapper_regs
	import mapper_pkg::*;
(
	input logic m2,
	input logic ppu_addr_in, // Async reset, active high
	input cpu_bus_t bus,
	output mapper_cfg_t cfg,
	output bank_regs_t banks,
	output irq_ctrl_t irq_ctl,
	output logic mmc3_sel
);

	logic lockout; // Freezes setup regs once set
	logic [2:0] bank_sel; // MMC3 target for $8001
	logic setup_wr;
	logic mapper_wr;

	assign setup_wr = ~bus.rw & bus.romsel & (bus.addr[14:12] == `SETUP_PAGE) & ~lockout;
	assign mapper_wr = ~bus.rw & ~bus.romsel; // $8000-$FFFF
	assign mmc3_sel = (cfg.mapper == MAPPER_MMC3);

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			cfg <= '0;
			cfg.mapper <= MAPPER_NROM;
			cfg.mirroring <= MIRR_VERTICAL;
			banks <= '0;
			irq_ctl <= '0;
			lockout <= 1'b0;
			bank_sel <= 3'd0;
		end
		else
		begin
			irq_ctl.reload <= 1'b0; // Pulse, held only one cycle
			if (setup_wr)
			begin
				case (bus.addr[2:0])
					3'd0: cfg.flash_base[12:8] <= bus.data[4:0]; // A26-A22
					3'd1: cfg.flash_base[7:0] <= bus.data; // A21-A14
					3'd2: cfg.prg_mask <= bus.data[4:0];
					3'd3: banks.bank[0] <= bus.data; // Direct CHR bank
					3'd4: cfg.chr_mask <= bus.data[4:0];
					3'd5:
					begin
						banks.bank[1][5:0] <= bus.data[7:2]; // Direct PRG bank
						cfg.sram_page <= bus.data[1:0];
					end
					3'd6: cfg.mapper <= mapper_e'(bus.data[`MAPPER_W-1:0]); // Flags dropped
					3'd7:
					begin
						lockout <= bus.data[7];
						cfg.mirroring <= mirroring_e'(bus.data[4:3]);
						cfg.prg_wr_en <= bus.data[2];
						cfg.chr_wr_en <= bus.data[1];
						cfg.sram_en <= bus.data[0];
					end
				endcase
			end
			else if (mapper_wr)
			begin
				case (cfg.mapper)
					MAPPER_UXROM: banks.bank[1] <= bus.data; // 16 KiB at $8000
					MAPPER_CNROM: banks.bank[0] <= bus.data; // 8 KiB CHR
					MAPPER_AXROM:
					begin
						banks.bank[1][3:0] <= bus.data[3:0]; // 32 KiB PRG
						cfg.mirroring <= mirroring_e'({1'b1, bus.data[4]}); // One screen
					end
					MAPPER_MMC3:
					begin
						case ({bus.addr[14:13], bus.addr[0]})
							3'b000: // $8000 bank select
							begin
								banks.chr_mode <= bus.data[7];
								banks.prg_mode <= bus.data[6];
								bank_sel <= bus.data[2:0];
							end
							3'b001: banks.bank[bank_sel] <= bus.data; // $8001
							3'b010: cfg.mirroring <= mirroring_e'({1'b0, bus.data[0]}); // $A000
							3'b100: irq_ctl.latch <= bus.data; // $C000
							3'b101: irq_ctl.reload <= 1'b1; // $C001
							3'b110: irq_ctl.enable <= 1'b0; // $E000, also acks
							3'b111: irq_ctl.enable <= 1'b1; // $E001
							default: ; // $A001 RAM protect not kept
						endcase
					end
					default: ; // NROM has no registers
				endcase
			end
		end
	end

endmodule

//--- prg_bank_map.sv
`include "mapper_params.svh"

module prg_bank_map
	import mapper_pkg::*;
(
	input cpu_addr_t bus_addr,
	input logic romsel, // Low for $8000-$FFFF
	input logic rw,
	input mapper_cfg_t cfg,
	input bank_regs_t banks,
	output logic [26:13] cpu_addr_out,
	output logic flash_we,
	output logic flash_oe,
	output logic sram_ce,
	output logic sram_we,
	output logic sram_oe
);

	prg_bank_t prg_bank; // Mapped A18-A13 before masking
	flash_base_t flash_hi; // Final A26-A14

	always_comb
	begin
		case (cfg.mapper)
			MAPPER_UXROM, MAPPER_CNROM: // Switchable $8000, fixed $C000
				prg_bank = {bus_addr[14] ? `LAST_PRG_BANK : banks.bank[1][4:0], bus_addr[13]};
			MAPPER_MMC3:
			begin
				case ({bus_addr[14:13], banks.prg_mode})
					3'b000: prg_bank = banks.bank[6][5:0]; // $8000, mode 0
					3'b001: prg_bank = {`LAST_PRG_BANK, 1'b0}; // Second last
					3'b010, 3'b011: prg_bank = banks.bank[7][5:0]; // $A000 always r7
					3'b100: prg_bank = {`LAST_PRG_BANK, 1'b0};
					3'b101: prg_bank = banks.bank[6][5:0]; // $C000, mode 1
					default: prg_bank = {`LAST_PRG_BANK, 1'b1}; // $E000 fixed last
				endcase
			end
			default: prg_bank = {banks.bank[1][3:0], bus_addr[14:13]}; // NROM, AxROM 32 KiB
		endcase
	end

	assign flash_hi = cfg.flash_base | flash_base_t'(prg_bank[5:1] & ~cfg.prg_mask);

	// SRAM page on the same lines for $6000-$7FFF
	assign cpu_addr_out = romsel ? {12'b0, cfg.sram_page} : {flash_hi, prg_bank[0]};

	assign flash_we = rw | romsel | ~cfg.prg_wr_en; // Flash writes only when enabled
	assign flash_oe = ~rw | romsel;
	assign sram_ce = ~(bus_addr[14] & bus_addr[13] & romsel & cfg.sram_en); // $6000-$7FFF
	assign sram_we = rw;
	assign sram_oe = ~rw;

endmodule

//--- chr_bank_map.sv
module chr_bank_map
	import mapper_pkg::*;
(
	input ppu_addr_t ppu_addr,
	input logic ppu_rd_in,
	input logic ppu_wr_in,
	input mapper_cfg_t cfg,
	input bank_regs_t banks,
	output chr_bank_t ppu_addr_out,
	output logic ppu_rd_out,
	output logic ppu_wr_out,
	output logic ppu_ciram_a10
);

	chr_bank_t chr_bank; // Mapped A17-A10 before masking

	always_comb
	begin
		if (cfg.mapper == MAPPER_MMC3)
		begin
			if (ppu_addr[12] == banks.chr_mode) // 2 KiB half
			begin
				if (ppu_addr[11])
					chr_bank = {banks.bank[1][7:1], ppu_addr[10]};
				else
					chr_bank = {banks.bank[0][7:1], ppu_addr[10]};
			end
			else
			begin
				case (ppu_addr[11:10]) // 1 KiB half
					2'b00: chr_bank = banks.bank[2];
					2'b01: chr_bank = banks.bank[3];
					2'b10: chr_bank = banks.bank[4];
					default: chr_bank = banks.bank[5];
				endcase
			end
		end
		else
			chr_bank = {banks.bank[0][4:0], ppu_addr[12:10]}; // Single 8 KiB bank
	end

	assign ppu_addr_out = {chr_bank[7:3] & ~cfg.chr_mask, chr_bank[2:0]}; // Mask A17-A13

	// Nametable space goes to CIRAM, not CHR
	assign ppu_rd_out = ppu_rd_in | ppu_addr[13];
	assign ppu_wr_out = ppu_wr_in | ppu_addr[13] | ~cfg.chr_wr_en; // CHR RAM only

	always_comb
	begin
		case (cfg.mirroring)
			MIRR_VERTICAL: ppu_ciram_a10 = ppu_addr[10];
			MIRR_HORIZONTAL: ppu_ciram_a10 = ppu_addr[11];
			MIRR_ONE_A: ppu_ciram_a10 = 1'b0;
			default: ppu_ciram_a10 = 1'b1; // One screen B
		endcase
	end

endmodule

//--- scanline_irq.sv
`include "mapper_params.svh"

module scanline_irq
	import mapper_pkg::*;
(
	input logic m2,
	input logic ppu_addr_in, // Async reset, active high
	input logic a12, // PPU A12, sampled on m2
	input irq_ctrl_t irq_ctl,
	input logic mmc3_sel,
	output logic irq // Active low
);

	localparam int LOW_W = $clog2(`A12_LOW_CYCLES + 1);

	logic [LOW_W-1:0] a12_low_cnt; // Saturating low-time count
	logic a12_rise; // Filtered A12 edge
	cpu_data_t counter;
	cpu_data_t counter_next;
	logic reload_pend; // Set by $C001, used at next clock
	logic irq_flag;

	assign a12_rise = mmc3_sel & a12 & (a12_low_cnt == LOW_W'(`A12_LOW_CYCLES));

	// Reload on request or when exhausted
	assign counter_next = (reload_pend || counter == 8'd0) ? irq_ctl.latch : counter - 8'd1;

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
			a12_low_cnt <= '0;
		else if (a12)
			a12_low_cnt <= '0; // Any high sample restarts filter
		else if (a12_low_cnt != LOW_W'(`A12_LOW_CYCLES))
			a12_low_cnt <= a12_low_cnt + 1'b1;
	end

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			counter <= 8'd0;
			reload_pend <= 1'b0;
		end
		else
		begin
			if (a12_rise)
				counter <= counter_next;
			reload_pend <= irq_ctl.reload | (reload_pend & ~a12_rise); // Consumed by clock
		end
	end

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
			irq_flag <= 1'b0;
		else if (!irq_ctl.enable)
			irq_flag <= 1'b0; // Disable doubles as ack
		else if (a12_rise && counter_next == 8'd0)
			irq_flag <= 1'b1;
	end

	assign irq = ~(irq_flag & mmc3_sel); // Quiet for other mappers

endmodule

//--- cart_mapper.sv
module cart_mapper
	import mapper_pkg::*;
(
	input logic m2,
	input logic ppu_addr_in, // Async reset, active high
	input logic romsel,
	input logic cpu_rw_in,
	input cpu_addr_t cpu_addr_in,
	input cpu_data_t cpu_data_in,
	output logic [26:13] cpu_addr_out,
	output logic flash_we,
	output logic flash_oe,
	output logic sram_ce,
	output logic sram_we,
	output logic sram_oe,
	input logic ppu_rd_in,
	input logic ppu_wr_in,
	input ppu_addr_t ppu_addr,
	output chr_bank_t ppu_addr_out,
	output logic ppu_rd_out,
	output logic ppu_wr_out,
	output logic ppu_ciram_a10,
	output logic irq // Active low
);

	cpu_bus_t bus;
	mapper_cfg_t cfg;
	bank_regs_t banks;
	irq_ctrl_t irq_ctl;
	logic mmc3_sel;

	assign bus = '{romsel: romsel, rw: cpu_rw_in, addr: cpu_addr_in, data: cpu_data_in};

	mapper_regs i_mapper_regs (
		.m2(m2),
		.ppu_addr_in(ppu_addr_in),
		.bus(bus),
		.cfg(cfg),
		.banks(banks),
		.irq_ctl(irq_ctl),
		.mmc3_sel(mmc3_sel)
	);

	prg_bank_map i_prg_bank_map (
		.bus_addr(cpu_addr_in),
		.romsel(romsel),
		.rw(cpu_rw_in),
		.cfg(cfg),
		.banks(banks),
		.cpu_addr_out(cpu_addr_out),
		.flash_we(flash_we),
		.flash_oe(flash_oe),
		.sram_ce(sram_ce),
		.sram_we(sram_we),
		.sram_oe(sram_oe)
	);

	chr_bank_map i_chr_bank_map (
		.ppu_addr(ppu_addr),
		.ppu_rd_in(ppu_rd_in),
		.ppu_wr_in(ppu_wr_in),
		.cfg(cfg),
		.banks(banks),
		.ppu_addr_out(ppu_addr_out),
		.ppu_rd_out(ppu_rd_out),
		.ppu_wr_out(ppu_wr_out),
		.ppu_ciram_a10(ppu_ciram_a10)
	);

	scanline_irq i_scanline_irq (
		.m2(m2),
		.ppu_addr_in(ppu_addr_in),
		.a12(ppu_addr[12]), // Scanline clock source
		.irq_ctl(irq_ctl),
		.mmc3_sel(mmc3_sel),
		.irq(irq)
	);

endmodule

//--- tb_cart_mapper.sv
`include "mapper_params.svh"

module tb_cart_mapper
	import mapper_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [2:0] K_WR = 3'd0; // CPU write
	localparam logic [2:0] K_PRG = 3'd1; // CPU side address and strobes
	localparam logic [2:0] K_CHR = 3'd2; // PPU side address, A10, strobes
	localparam logic [2:0] K_A12 = 3'd3; // A12 low for data cycles, then high
	localparam logic [2:0] K_IRQ = 3'd4; // irq within the current cycle

	// exp holds {sram_oe, sram_we, flash_we, sram_ce, flash_oe, cpu_addr_out}
	// or {rd_out, wr_out, a10, chr} or irq in bit 0
	typedef struct packed {
		logic [2:0] kind;
		logic [15:0] addr; // A15 low means romsel high
		logic [7:0] data;
		logic [18:0] exp;
	} step_t;

	logic m2;
	logic ppu_addr_in; // Reset
	logic romsel;
	logic cpu_rw_in;
	cpu_addr_t cpu_addr_in;
	cpu_data_t cpu_data_in;
	logic [26:13] cpu_addr_out;
	logic flash_we;
	logic flash_oe;
	logic sram_ce;
	logic sram_we;
	logic sram_oe;
	logic ppu_rd_in;
	logic ppu_wr_in;
	ppu_addr_t ppu_addr;
	chr_bank_t ppu_addr_out;
	logic ppu_rd_out;
	logic ppu_wr_out;
	logic ppu_ciram_a10;
	logic irq;

	step_t steps[$];
	logic table_ready = 1'b0;
	int errors = 0;
	int checks = 0;

	// Values the table is built from
	flash_base_t base;
	bank_mask_t pmask;
	prg_bank_t pb;
	sram_page_t page;
	bank_reg_t ub;
	bank_reg_t cb;
	bank_reg_t ab;
	bank_reg_t rb[8]; // MMC3 r0-r7
	logic prg_wr; // Flash writes enabled in setup reg 7

	cart_mapper i_cart_mapper (.*);

	always #5 m2 = ~m2;

	// Flash read with sram_ce high, flash_oe low and base ORed with masked bank
	function automatic logic [18:0] flash_exp(input prg_bank_t p);
		return {3'b011, 1'b1, 1'b0, base | flash_base_t'(p[5:1] & ~pmask), p[0]};
	endfunction

	function automatic logic [18:0] chr_exp(input chr_bank_t b, input logic a10, input logic wr,
		input logic rd);
		return {8'b0, rd, wr, a10, b};
	endfunction

	task automatic add_step(input logic [2:0] kind, input logic [15:0] addr,
		input logic [7:0] data, input logic [18:0] exp);
		steps.push_back('{kind: kind, addr: addr, data: data, exp: exp});
	endtask

	// Writes expect sram_we low and flash_we low only in ROM space with PRG writes on
	task automatic add_write(input logic [15:0] addr, input logic [7:0] data);
		add_step(K_WR, addr, data, {1'b1, 1'b0, ~(addr[15] & prg_wr), 16'b0});
	endtask

	task automatic check_prg(input logic [26:13] got, input logic [26:13] exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_chr(input chr_bank_t got, input chr_bank_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED %0d ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic build_table();
		base = {5'h0B, 8'h60}; // Low five bits clear so the bank shows through
		pmask = '0;
		prg_wr = 1'b0;
		pb = prg_bank_t'($urandom);
		page = sram_page_t'($urandom);
		ub = bank_reg_t'($urandom);
		cb = bank_reg_t'($urandom);
		ab = bank_reg_t'($urandom);
		foreach (rb[i])
			rb[i] = bank_reg_t'($urandom);
		// Setup and NROM
		add_write(16'h5000, 8'h0B);
		add_write(16'h5001, 8'h60);
		add_write(16'h5005, {pb, page});
		add_write(16'h5007, 8'h01); // SRAM on, vertical
		add_step(K_PRG, 16'h8000, '0, flash_exp({pb[3:0], 2'b00}));
		add_step(K_PRG, 16'hC000, '0, flash_exp({pb[3:0], 2'b10}));
		add_step(K_PRG, 16'h6000, '0, {3'b011, 2'b01, 12'b0, page});
		// UxROM
		add_write(16'h5006, 8'(`MAP_UXROM));
		add_write(16'h8000, ub);
		add_step(K_PRG, 16'h8000, '0, flash_exp({ub[4:0], 1'b0}));
		add_step(K_PRG, 16'hC000, '0, flash_exp({`LAST_PRG_BANK, 1'b0}));
		add_write(16'h5002, 8'h14);
		pmask = 5'h14;
		add_step(K_PRG, 16'hA000, '0, flash_exp({ub[4:0], 1'b1}));
		add_step(K_PRG, 16'hC000, '0, flash_exp({`LAST_PRG_BANK, 1'b0}));
		add_write(16'h5002, 8'h00);
		pmask = '0;
		// CNROM then AxROM
		add_write(16'h5006, 8'(`MAP_CNROM));
		add_write(16'h8000, cb);
		add_step(K_CHR, 16'h0000, '0, chr_exp({cb[4:0], 3'b000}, 1'b0, 1'b1, 1'b0));
		add_step(K_CHR, 16'h1C00, '0, chr_exp({cb[4:0], 3'b111}, 1'b1, 1'b1, 1'b0));
		add_write(16'h5007, 8'h09); // Horizontal
		add_step(K_CHR, 16'h2800, '0, chr_exp({cb[4:0], 3'b010}, 1'b1, 1'b1, 1'b1));
		add_step(K_CHR, 16'h2400, '0, chr_exp({cb[4:0], 3'b001}, 1'b0, 1'b1, 1'b1));
		add_write(16'h5006, 8'(`MAP_AXROM));
		add_write(16'h8000, {3'b000, 1'b1, ab[3:0]}); // Screen B
		add_step(K_PRG, 16'hE000, '0, flash_exp({ab[3:0], 2'b11}));
		add_step(K_CHR, 16'h2000, '0, chr_exp({cb[4:0], 3'b000}, 1'b1, 1'b1, 1'b1));
		add_write(16'h8000, {4'b0000, ab[3:0]}); // Screen A
		add_step(K_CHR, 16'h2400, '0, chr_exp({cb[4:0], 3'b001}, 1'b0, 1'b1, 1'b1));
		// MMC3 banking
		add_write(16'h5007, 8'h01);
		add_write(16'h5006, 8'(`MAP_MMC3));
		for (int r = 0; r < 8; r++)
		begin
			add_write(16'h8000, 8'(r)); // Both modes 0
			add_write(16'h8001, rb[r]);
		end
		add_step(K_PRG, 16'h8000, '0, flash_exp(rb[6][5:0]));
		add_step(K_PRG, 16'hA000, '0, flash_exp(rb[7][5:0]));
		add_step(K_PRG, 16'hC000, '0, flash_exp({`LAST_PRG_BANK, 1'b0}));
		add_step(K_PRG, 16'hE000, '0, flash_exp({`LAST_PRG_BANK, 1'b1}));
		add_step(K_CHR, 16'h0400, '0, chr_exp({rb[0][7:1], 1'b1}, 1'b1, 1'b1, 1'b0));
		add_step(K_CHR, 16'h0800, '0, chr_exp({rb[1][7:1], 1'b0}, 1'b0, 1'b1, 1'b0));
		add_step(K_CHR, 16'h1000, '0, chr_exp(rb[2], 1'b0, 1'b1, 1'b0));
		add_step(K_CHR, 16'h1C00, '0, chr_exp(rb[5], 1'b1, 1'b1, 1'b0));
		add_write(16'h8000, 8'hC6); // CHR and PRG modes 1
		add_step(K_PRG, 16'h8000, '0, flash_exp({`LAST_PRG_BANK, 1'b0}));
		add_step(K_PRG, 16'hC000, '0, flash_exp(rb[6][5:0]));
		add_step(K_CHR, 16'h1000, '0, chr_exp({rb[0][7:1], 1'b0}, 1'b0, 1'b1, 1'b0));
		add_step(K_CHR, 16'h1C00, '0, chr_exp({rb[1][7:1], 1'b1}, 1'b1, 1'b1, 1'b0));
		add_step(K_CHR, 16'h0000, '0, chr_exp(rb[2], 1'b0, 1'b1, 1'b0));
		add_step(K_CHR, 16'h0C00, '0, chr_exp(rb[5], 1'b1, 1'b1, 1'b0));
		add_write(16'hA000, 8'h01); // Horizontal
		add_step(K_CHR, 16'h0800, '0, chr_exp(rb[4], 1'b1, 1'b1, 1'b0));
		add_write(16'h5007, 8'h07); // CHR RAM and flash writes on
		prg_wr = 1'b1;
		add_step(K_CHR, 16'h0000, '0, chr_exp(rb[2], 1'b0, 1'b0, 1'b0));
		// MMC3 IRQ with latch 2 so the third filtered pulse fires
		add_write(16'hC000, 8'h02);
		add_write(16'hC001, 8'h00);
		add_write(16'hE001, 8'h00);
		add_step(K_A12, '0, 8'd3, '0);
		add_step(K_A12, '0, 8'd3, '0);
		add_step(K_IRQ, '0, '0, 19'd1);
		add_step(K_A12, '0, 8'd2, '0); // Too short, filtered out
		add_step(K_A12, '0, 8'd1, '0);
		add_step(K_IRQ, '0, '0, 19'd1);
		add_step(K_A12, '0, 8'd3, '0);
		add_step(K_IRQ, '0, '0, 19'd0); // Low from the clocking edge
		add_write(16'hE000, 8'h00);
		add_step(K_IRQ, '0, '0, 19'd0); // Flag clears one edge after the write
		add_step(K_IRQ, '0, '0, 19'd1);
		// Lockout freezes the setup page
		add_write(16'h5007, 8'h81);
		prg_wr = 1'b0;
		add_write(16'h5001, 8'hFF);
		add_write(16'h5006, 8'(`MAP_NROM));
		add_step(K_PRG, 16'hE000, '0, flash_exp({`LAST_PRG_BANK, 1'b1}));
	endtask

	task automatic run_step(input step_t s);
		case (s.kind)
			K_WR:
			begin
				@(posedge m2);
				romsel <= ~s.addr[15];
				cpu_rw_in <= 1'b0;
				cpu_addr_in <= s.addr[14:0];
				cpu_data_in <= s.data;
				@(negedge m2); // Write strobes mid cycle
				check_bit(flash_we, s.exp[16], "flash_we");
				check_bit(sram_we, s.exp[17], "sram_we");
				check_bit(sram_oe, s.exp[18], "sram_oe");
				@(posedge m2); // Write taken here
				cpu_rw_in <= 1'b1;
			end
			K_PRG:
			begin
				@(posedge m2);
				romsel <= ~s.addr[15];
				cpu_addr_in <= s.addr[14:0];
				@(negedge m2);
				check_prg(cpu_addr_out, s.exp[13:0], "cpu_addr_out");
				check_bit(flash_oe, s.exp[14], "flash_oe");
				check_bit(sram_ce, s.exp[15], "sram_ce");
				check_bit(flash_we, s.exp[16], "flash_we");
				check_bit(sram_we, s.exp[17], "sram_we");
				check_bit(sram_oe, s.exp[18], "sram_oe");
			end
			K_CHR:
			begin
				@(posedge m2);
				ppu_addr <= s.addr[13:0];
				@(negedge m2);
				check_chr(ppu_addr_out, s.exp[7:0], "ppu_addr_out");
				check_bit(ppu_ciram_a10, s.exp[8], "ppu_ciram_a10");
				check_bit(ppu_wr_out, s.exp[9], "ppu_wr_out");
				check_bit(ppu_rd_out, s.exp[10], "ppu_rd_out");
			end
			K_A12:
			begin
				@(posedge m2);
				ppu_addr[12] <= 1'b0;
				repeat (s.data) @(posedge m2); // Low samples seen by the filter
				ppu_addr[12] <= 1'b1;
				@(posedge m2); // Counter clocks here if the filter passed
			end
			K_IRQ:
			begin
				@(negedge m2); // Same cycle as the last edge of the step before
				check_bit(irq, s.exp[0], "irq");
			end
			default:
			begin
				errors++;
				$display("Table holds an unknown step kind %0d", s.kind);
			end
		endcase
	endtask

	initial
	begin
		int errs_before;
		m2 = 1'b0;
		ppu_addr_in = 1'b1;
		romsel = 1'b1;
		cpu_rw_in = 1'b1;
		cpu_addr_in = '0;
		cpu_data_in = '0;
		ppu_rd_in = 1'b0; // PPU strobes held active
		ppu_wr_in = 1'b0;
		ppu_addr = '0;
		void'($urandom(32'hb7f805f2));
		build_table();
		table_ready = 1'b1;
		repeat (3) @(posedge m2);
		ppu_addr_in <= 1'b0;
		foreach (steps[i])
		begin
			errs_before = errors;
			run_step(steps[i]);
			$display("step %0d kind %0d addr %h %s", i, steps[i].kind, steps[i].addr,
				(errors == errs_before) ? "ok" : "mismatch");
		end
		$display("%0d steps, %0d checks, %0d errors", steps.size(), checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Watchdog allows 20 cycles of 10 ns per step
	initial
	begin
		wait (table_ready);
		#((steps.size() + 1) * 200);
		$display("Timeout: the steps did not finish in the allowed time");
		$display("** FAIL **");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+.
mapper_pkg.sv
mapper_regs.sv
prg_bank_map.sv
chr_bank_map.sv
scanline_irq.sv
cart_mapper.sv
tb_cart_mapper.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_cart_mapper \
	-o tb_cart_mapper \
	&& ./obj_dir/tb_cart_mapper | tee sim.log \
	|| { echo "Build or simulation run failed"; exit 1; }
grep -qx '\*\* PASS \*\*' sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
